/* vlog.f */
+incdir+logic
logic/fetch_pkg.sv
logic/icache_pkg.sv
logic/fetch_ctrl.sv
logic/icache_array.sv
logic/fetch_out.sv
logic/ifu_top.sv
dv/ifu_checker.sv
dv/ifu_tb.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module ifu_tb -Mdir build -f vlog.f
	./build/Vifu_tb > sim.log 2>&1 || true
	cat sim.log
	! grep -q "FAIL: see errors above" sim.log
	grep -q "PASS: all tests" sim.log

clean:
	rm -rf build sim.log

/* dv/ifu_tb.sv */
`timescale 1ns/1ps
`include "ifu_macros.svh"

module ifu_tb;
  import fetch_pkg::*;

  localparam int TIMEOUT = 50;
  localparam int RAND_FETCHES = 300;
  localparam logic [31:0] MEM_KEY = 32'h5A5A_1234;

  logic  clk;
  logic  rst;
  logic  req_valid_i;
  pc_t   req_pc_i;
  logic  flush_i;
  logic  ready_o;
  logic  valid_o;
  logic  next_ready_i;
  inst_t inst_o;
  pc_t   pc_o;
  pc_t   mem_araddr_o;
  logic  mem_arvalid_o;
  inst_t mem_rdata_i;
  logic  mem_rvalid_i;

  integer seed;
  integer mem_wait;
  integer bus_reads;
  integer exp_reads;
  pc_t    bus_addr;

  // tag and valid shadow of the cache
  logic                  model_valid [`IFU_LINES];
  logic [`IFU_TAG_W-1:0] model_tag   [`IFU_LINES];

  // few indices, two tags each, so lines get evicted
  logic [`IFU_IDX_W-1:0] idx_pool [4];
  logic [`IFU_TAG_W-1:0] tag_pool [2];

  ifu_top uut (
    .clk           (clk),
    .rst           (rst),
    .req_valid_i   (req_valid_i),
    .req_pc_i      (req_pc_i),
    .flush_i       (flush_i),
    .ready_o       (ready_o),
    .valid_o       (valid_o),
    .next_ready_i  (next_ready_i),
    .inst_o        (inst_o),
    .pc_o          (pc_o),
    .mem_araddr_o  (mem_araddr_o),
    .mem_arvalid_o (mem_arvalid_o),
    .mem_rdata_i   (mem_rdata_i),
    .mem_rvalid_i  (mem_rvalid_i)
  );

  always #5 clk = ~clk;

  // bus memory, answers after 1 to 4 cycles with address ^ key
  always
  begin
    @(posedge clk);
    #1;
    if (rst || mem_rvalid_i)
    begin
      mem_rvalid_i = 1'b0;
      mem_wait = -1;
    end
    else if (mem_arvalid_o)
    begin
      if (mem_wait < 0)
      begin
        mem_wait = {$random(seed)} % 4;
        bus_reads = bus_reads + 1;
        bus_addr = mem_araddr_o;
      end
      if (mem_wait == 0)
      begin
        mem_rdata_i = mem_araddr_o ^ MEM_KEY;
        mem_rvalid_i = 1'b1;
      end
      else
        mem_wait = mem_wait - 1;
    end
  end

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("FAIL: see errors above");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_inst(input string name, input inst_t got, input inst_t exp);
    if (got !== exp)
      fail_run($sformatf("Fail %s: got %h, expected %h", name, got, exp));
  endtask

  task automatic check_pc(input string name, input pc_t got, input pc_t exp);
    if (got !== exp)
      fail_run($sformatf("Fail %s: got %h, expected %h", name, got, exp));
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp)
      fail_run($sformatf("Fail %s: got %h, expected %h", name, got, exp));
  endtask

  // one cycle; inputs change 1 ns after the edge
  task automatic step();
    logic [31:0] r;
    @(posedge clk);
    #1;
    r = $random(seed);
    next_ready_i = (r[1:0] != 2'b00);
  endtask

  task automatic wait_ready();
    integer cycles;
    cycles = 0;
    while (!ready_o)
    begin
      step();
      cycles = cycles + 1;
      if (cycles > TIMEOUT)
        fail_run("timeout waiting for ready_o");
    end
  endtask

  function automatic logic model_hit(input pc_t pc);
    logic [`IFU_IDX_W-1:0] idx;
    idx = pc[`IFU_OFS_W +: `IFU_IDX_W];
    return model_valid[idx] && (model_tag[idx] == pc[`IFU_ADDR_W-1 -: `IFU_TAG_W]);
  endfunction

  task automatic model_fill(input pc_t pc);
    logic [`IFU_IDX_W-1:0] idx;
    idx = pc[`IFU_OFS_W +: `IFU_IDX_W];
    model_valid[idx] = 1'b1;
    model_tag[idx] = pc[`IFU_ADDR_W-1 -: `IFU_TAG_W];
  endtask

  task automatic pulse_flush();
    integer i;
    wait_ready();
    flush_i = 1'b1;
    step();
    flush_i = 1'b0;
    for (i = 0; i < `IFU_LINES; i++)
      model_valid[i] = 1'b0;
  endtask

  function automatic pc_t pick_pc();
    logic [31:0] r;
    r = $random(seed);
    return {tag_pool[r[4]], idx_pool[r[1:0]], 2'b00};
  endfunction

  // one request through accept, lookup or bus read, and the decode handoff
  task automatic fetch(input pc_t pc);
    logic   exp_hit;
    logic   took;
    inst_t  exp_inst;
    integer reads_before;
    integer cycles;
    exp_hit = model_hit(pc);
    exp_inst = pc ^ MEM_KEY;
    wait_ready();
    check_bit("valid_o", valid_o, 1'b0);
    reads_before = bus_reads;
    req_valid_i = 1'b1;
    req_pc_i = pc;
    step();
    req_valid_i = 1'b0;
    cycles = 1;
    while (!valid_o)
    begin
      step();
      cycles = cycles + 1;
      if (cycles > TIMEOUT)
        fail_run($sformatf("timeout waiting for valid_o on pc %h", pc));
    end
    if (exp_hit)
    begin
      if (bus_reads != reads_before)
        fail_run($sformatf("unexpected bus read for cached pc %h", pc));
      if (cycles != 2)
        fail_run($sformatf("cached pc %h took %0d cycles, expected 2", pc, cycles));
    end
    else
    begin
      if (bus_reads != reads_before + 1)
        fail_run($sformatf("pc %h should miss with one bus read, saw %0d",
                           pc, bus_reads - reads_before));
      check_pc("mem_araddr_o", bus_addr, pc);
      exp_reads = exp_reads + 1;
      model_fill(pc);
    end
    // hold under back-pressure until decode takes the word
    cycles = 0;
    took = 1'b0;
    while (!took)
    begin
      check_bit("ready_o", ready_o, 1'b0);
      check_inst("inst_o", inst_o, exp_inst);
      check_pc("pc_o", pc_o, pc);
      took = next_ready_i;
      step();
      if (!took)
      begin
        check_bit("valid_o", valid_o, 1'b1);
        cycles = cycles + 1;
        if (cycles > TIMEOUT)
          fail_run("timeout waiting for decode to take the word");
      end
    end
    check_bit("valid_o", valid_o, 1'b0);
    check_bit("ready_o", ready_o, 1'b1);
  endtask

  initial
  begin
    integer      n;
    integer      i;
    pc_t         pc_a;
    pc_t         pc_b;
    logic [31:0] r;
    seed = 64575;
    clk = 1'b0;
    rst = 1'b1;
    req_valid_i = 1'b0;
    req_pc_i = '0;
    flush_i = 1'b0;
    next_ready_i = 1'b1;
    mem_rdata_i = '0;
    mem_rvalid_i = 1'b0;
    mem_wait = -1;
    bus_reads = 0;
    exp_reads = 0;
    bus_addr = '0;
    idx_pool[0] = 8'd3;
    idx_pool[1] = 8'd17;
    idx_pool[2] = 8'd200;
    idx_pool[3] = 8'd255;
    tag_pool[0] = 22'h000040;
    tag_pool[1] = 22'h2A0F1;
    for (i = 0; i < `IFU_LINES; i++)
    begin
      model_valid[i] = 1'b0;
      model_tag[i] = '0;
    end
    repeat (4) step();
    check_bit("valid_o", valid_o, 1'b0);
    check_bit("mem_arvalid_o", mem_arvalid_o, 1'b0);
    check_bit("ready_o", ready_o, 1'b1);
    rst = 1'b0;
    step();

    // miss, hit, conflict eviction, then refetch after flush
    pc_a = {tag_pool[0], idx_pool[1], 2'b00};
    pc_b = {tag_pool[1], idx_pool[1], 2'b00};
    fetch(pc_a);
    fetch(pc_a);
    fetch(pc_b);
    fetch(pc_a);
    fetch(pc_b);
    pulse_flush();
    fetch(pc_b);
    fetch(pc_b);

    for (n = 0; n < RAND_FETCHES; n++)
    begin
      r = $random(seed);
      if (r[3:0] == 4'd0)
        pulse_flush();
      fetch(pick_pc());
    end

    step();
    if (bus_reads == exp_reads)
    begin
      $display("PASS: all tests");
      $finish;
    end
    else
      fail_run($sformatf("saw %0d bus reads for %0d predicted misses", bus_reads, exp_reads));
  end

endmodule

/* dv/ifu_checker.sv */
`timescale 1ns/1ps

module ifu_checker (
  input logic             clk,
  input logic             rst,
  input logic             ready_i,
  input logic             valid_i,
  input logic             next_ready_i,
  input fetch_pkg::inst_t inst_i,
  input fetch_pkg::pc_t   pc_i,
  input fetch_pkg::pc_t   araddr_i,
  input logic             arvalid_i,
  input logic             rvalid_i
);

  // read request stays up with the same address until data arrives
  bus_hold: assert property (@(posedge clk) disable iff (rst)
    arvalid_i && !rvalid_i |=> arvalid_i && $stable(araddr_i))
    else $error("mem_arvalid_o or mem_araddr_o changed before mem_rvalid_i");

  // held word toward decode must not move under back-pressure
  out_hold: assert property (@(posedge clk) disable iff (rst)
    valid_i && !next_ready_i |=> valid_i && $stable(inst_i) && $stable(pc_i))
    else $error("inst_o or pc_o changed while valid_o waited for next_ready_i");

  // a decode transfer hands the unit back to the request side
  ready_handoff: assert property (@(posedge clk) disable iff (rst)
    valid_i && next_ready_i |=> ready_i && !valid_i)
    else $error("valid_o did not drop or ready_o did not rise after a transfer");

endmodule

bind ifu_top ifu_checker u_chk (
  .clk          (clk),
  .rst          (rst),
  .ready_i      (ready_o),
  .valid_i      (valid_o),
  .next_ready_i (next_ready_i),
  .inst_i       (inst_o),
  .pc_i         (pc_o),
  .araddr_i     (mem_araddr_o),
  .arvalid_i    (mem_arvalid_o),
  .rvalid_i     (mem_rvalid_i)
);

/* logic/ifu_top.sv */
`timescale 1ns/1ps

module ifu_top (
  input  logic             clk,
  input  logic             rst,
  input  logic             req_valid_i,
  input  fetch_pkg::pc_t   req_pc_i,
  input  logic             flush_i,
  output logic             ready_o,
  output logic             valid_o,
  input  logic             next_ready_i,
  output fetch_pkg::inst_t inst_o,
  output fetch_pkg::pc_t   pc_o,
  output fetch_pkg::pc_t   mem_araddr_o,
  output logic             mem_arvalid_o,
  input  fetch_pkg::inst_t mem_rdata_i,
  input  logic             mem_rvalid_i
);
  import fetch_pkg::*;
  import icache_pkg::*;

  logic         out_busy;
  icache_addr_u lookup_addr;
  logic         hit;
  inst_t        hit_data;
  logic         fill;
  inst_t        fill_data;
  logic         deliver;
  inst_t        deliver_inst;
  pc_t          deliver_pc;

  // request side, FSM and bus read
  fetch_ctrl u_ctrl (
    .clk            (clk),
    .rst            (rst),
    .req_valid_i    (req_valid_i),
    .req_pc_i       (req_pc_i),
    .out_busy_i     (out_busy),
    .ready_o        (ready_o),
    .lookup_addr_o  (lookup_addr),
    .hit_i          (hit),
    .hit_data_i     (hit_data),
    .fill_o         (fill),
    .fill_data_o    (fill_data),
    .deliver_o      (deliver),
    .deliver_inst_o (deliver_inst),
    .deliver_pc_o   (deliver_pc),
    .mem_araddr_o   (mem_araddr_o),
    .mem_arvalid_o  (mem_arvalid_o),
    .mem_rdata_i    (mem_rdata_i),
    .mem_rvalid_i   (mem_rvalid_i)
  );

  icache_array u_cache (
    .clk           (clk),
    .rst           (rst),
    .flush_i       (flush_i),
    .lookup_addr_i (lookup_addr),
    .fill_i        (fill),
    .fill_data_i   (fill_data),
    .hit_o         (hit),
    .hit_data_o    (hit_data)
  );

  // holding stage toward decode
  fetch_out u_out (
    .clk            (clk),
    .rst            (rst),
    .deliver_i      (deliver),
    .deliver_inst_i (deliver_inst),
    .deliver_pc_i   (deliver_pc),
    .next_ready_i   (next_ready_i),
    .busy_o         (out_busy),
    .valid_o        (valid_o),
    .inst_o         (inst_o),
    .pc_o           (pc_o)
  );

endmodule

/* logic/fetch_out.sv */
`timescale 1ns/1ps

module fetch_out (
  input  logic             clk,
  input  logic             rst,
  input  logic             deliver_i,
  input  fetch_pkg::inst_t deliver_inst_i,
  input  fetch_pkg::pc_t   deliver_pc_i,
  input  logic             next_ready_i,
  output logic             busy_o,
  output logic             valid_o,
  output fetch_pkg::inst_t inst_o,
  output fetch_pkg::pc_t   pc_o
);

  // holding a word blocks new requests upstream
  assign busy_o = valid_o;

  // valid stays up until decode takes the word
  always_ff @(posedge clk)
  begin
    if (rst)
      valid_o <= 1'b0;
    else if (deliver_i)
      valid_o <= 1'b1;
    else if (valid_o && next_ready_i)
      valid_o <= 1'b0;
  end

  // deliver only comes while empty, so the held word is never overwritten
  always_ff @(posedge clk)
  begin
    if (deliver_i)
    begin
      inst_o <= deliver_inst_i;
      pc_o   <= deliver_pc_i;
    end
  end

endmodule

/* logic/icache_array.sv */
`timescale 1ns/1ps
`include "ifu_macros.svh"

module icache_array (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     flush_i,
  input  icache_pkg::icache_addr_u lookup_addr_i,
  input  logic                     fill_i,
  input  fetch_pkg::inst_t         fill_data_i,
  output logic                     hit_o,
  output fetch_pkg::inst_t         hit_data_o
);
  import fetch_pkg::*;
  import icache_pkg::*;

  // one valid bit per line, tag and data in plain arrays
  logic [`IFU_LINES-1:0] valid_q;
  icache_tag_t           tag_mem  [`IFU_LINES];
  inst_t                 data_mem [`IFU_LINES];

  icache_tag_t tag;
  icache_idx_t idx;

  // split the address through the field view
  // offset is ignored, fetches are word aligned
  assign tag = lookup_addr_i.fields.tag;
  assign idx = lookup_addr_i.fields.idx;

  // combinational hit, answered in the same cycle as the lookup
  assign hit_o      = valid_q[idx] && (tag_mem[idx] == tag);
  assign hit_data_o = data_mem[idx];

  // flush behaves like fence.i and drops every line at once
  always_ff @(posedge clk)
  begin
    if (rst || flush_i)
      valid_q <= '0;
    else if (fill_i)
      valid_q[idx] <= 1'b1;
  end

  // a fill simply replaces whatever line sat at this index
  always_ff @(posedge clk)
  begin
    if (fill_i)
    begin
      tag_mem[idx]  <= tag;
      data_mem[idx] <= fill_data_i;
    end
  end

endmodule

/* logic/fetch_ctrl.sv */
`timescale 1ns/1ps

module fetch_ctrl (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     req_valid_i,
  input  fetch_pkg::pc_t           req_pc_i,
  input  logic                     out_busy_i,
  output logic                     ready_o,
  output icache_pkg::icache_addr_u lookup_addr_o,
  input  logic                     hit_i,
  input  fetch_pkg::inst_t         hit_data_i,
  output logic                     fill_o,
  output fetch_pkg::inst_t         fill_data_o,
  output logic                     deliver_o,
  output fetch_pkg::inst_t         deliver_inst_o,
  output fetch_pkg::pc_t           deliver_pc_o,
  output fetch_pkg::pc_t           mem_araddr_o,
  output logic                     mem_arvalid_o,
  input  fetch_pkg::inst_t         mem_rdata_i,
  input  logic                     mem_rvalid_i
);
  import fetch_pkg::*;

  localparam logic [1:0] ST_IDLE   = 2'd0;
  localparam logic [1:0] ST_LOOKUP = 2'd1;
  localparam logic [1:0] ST_BUS    = 2'd2;

  logic [1:0] state_q;
  pc_t        pc_q;
  logic       accept;

  // only one fetch in flight, and none while decode still holds a word
  assign ready_o = (state_q == ST_IDLE) && !out_busy_i;
  assign accept  = req_valid_i && ready_o;

  // the registered pc drives lookup, bus address and the pc toward decode
  assign lookup_addr_o.raw = pc_q;
  assign mem_araddr_o      = pc_q;
  assign deliver_pc_o      = pc_q;

  // arvalid is a level for the whole bus wait
  assign mem_arvalid_o = (state_q == ST_BUS);

  assign fill_o      = (state_q == ST_BUS) && mem_rvalid_i;
  assign fill_data_o = mem_rdata_i;

  // hit word in the lookup cycle, bus word on rvalid
  always_comb
  begin
    deliver_o      = 1'b0;
    deliver_inst_o = hit_data_i;
    if ((state_q == ST_LOOKUP) && hit_i)
    begin
      deliver_o = 1'b1;
    end
    else if (fill_o)
    begin
      deliver_o      = 1'b1;
      deliver_inst_o = mem_rdata_i;
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      state_q <= ST_IDLE;
    else
    begin
      case (state_q)
        ST_IDLE:   if (accept) state_q <= ST_LOOKUP;
        ST_LOOKUP: state_q <= hit_i ? ST_IDLE : ST_BUS;
        ST_BUS:    if (mem_rvalid_i) state_q <= ST_IDLE;
        default:   state_q <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (accept)
      pc_q <= req_pc_i;
  end

endmodule

/* logic/icache_pkg.sv */
`include "ifu_macros.svh"

package icache_pkg;

  // tag and index fields of a fetch address
  typedef logic [`IFU_TAG_W-1:0] icache_tag_t;
  typedef logic [`IFU_IDX_W-1:0] icache_idx_t;

  // lookup view, msb first
  typedef struct packed {
    icache_tag_t            tag;
    icache_idx_t            idx;
    logic [`IFU_OFS_W-1:0]  ofs;
  } icache_fields_t;

  // one fetch address word, read raw on the bus side
  // and split into fields by the cache
  typedef union packed {
    fetch_pkg::pc_t raw;
    icache_fields_t fields;
  } icache_addr_u;

endpackage

/* logic/fetch_pkg.sv */
`include "ifu_macros.svh"

package fetch_pkg;

  // program counter as carried from the core to decode
  typedef logic [`IFU_ADDR_W-1:0] pc_t;

  // raw instruction word from cache or bus
  typedef logic [`IFU_DATA_W-1:0] inst_t;

endpackage

/* logic/ifu_macros.svh */
`ifndef IFU_MACROS_SVH
`define IFU_MACROS_SVH

// word widths seen by the core and the bus
`define IFU_ADDR_W 32
`define IFU_DATA_W 32

// direct-mapped geometry, one word per line
// tag + index + offset must add up to the address width
`define IFU_IDX_W  8
`define IFU_OFS_W  2
`define IFU_TAG_W  22
`define IFU_LINES  256

`endif
